// ==== Makefile ====
TOP := tb_basic_system

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then echo "test incomplete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
verilog/soc_pkg.sv
verilog/wb_bus_if.sv
verilog/wb_decoder.sv
verilog/on_chip_ram.sv
verilog/timer.sv
verilog/gpio.sv
verilog/interrupt_controller.sv
verilog/basic_system.sv
tb/tb_clock_gen.sv
tb/tb_basic_system.sv

// ==== tb/tb_basic_system.sv ====
`timescale 1ns/1ps

module tb_basic_system;

    import soc_pkg::*;

    // About 200 transfers of 3 cycles plus the timer waits, five times over
    localparam int TIMEOUT_CYCLES = (200 * 3 + 4 * 40) * 5;
    localparam int XFER_WAIT      = 16;
    // Response is seen on the second falling edge after the request
    localparam int RESP_SAMPLE    = 2;
    localparam int TEST_WORDS     = 64;
    localparam wb_addr_t UNMAPPED = 32'h2000_0000;

    logic     clk;
    logic     rst_n;
    logic     wb_cyc, wb_stb, wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w, wb_dat_r;
    wb_sel_t  wb_sel;
    logic     wb_ack, wb_err;
    gpio_t    gpio_in, gpio_out, gpio_oe;
    logic     irq, irq_ack;
    irq_vec_t irq_vector;

    // Shadow copies of the DUT state
    wb_data_t   shadow_ram [RAM_WORDS];
    gpio_t      shadow_out, shadow_oe, shadow_in, shadow_irq;
    logic [1:0] shadow_ctrl;
    wb_data_t   shadow_cmp;

    integer      seed = 92;
    int          data_errs, err_errs, vec_errs, other_errs;
    int          cycle_count = 0;
    logic [31:0] pick;
    wb_data_t    rdata;
    logic        ack_seen, err_seen, irq_seen;

    tb_clock_gen #(.PERIOD_NS(8.0)) u_clk (.clk_o(clk));

    basic_system u_dut (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .wb_cyc_i     ( wb_cyc     ),
        .wb_stb_i     ( wb_stb     ),
        .wb_we_i      ( wb_we      ),
        .wb_adr_i     ( wb_adr     ),
        .wb_dat_i     ( wb_dat_w   ),
        .wb_sel_i     ( wb_sel     ),
        .wb_dat_o     ( wb_dat_r   ),
        .wb_ack_o     ( wb_ack     ),
        .wb_err_o     ( wb_err     ),
        .gpio_in_i    ( gpio_in    ),
        .gpio_out_o   ( gpio_out   ),
        .gpio_oe_o    ( gpio_oe    ),
        .irq_o        ( irq        ),
        .irq_vector_o ( irq_vector ),
        .irq_ack_i    ( irq_ack    )
    );

    // ==================================================
    // Reference model
    // ==================================================

    function automatic wb_addr_t reg_addr(wb_addr_t base, logic [1:0] idx);
        return base + wb_addr_t'({idx, 2'b00});
    endfunction

    function automatic wb_data_t model_read(wb_addr_t adr);
        wb_data_t value;
        value = '0;
        if (adr - RAM_BASE < wb_addr_t'(RAM_WORDS * 4)) begin
            value = shadow_ram[adr[$clog2(RAM_WORDS)+1:2]];
        end else if (adr - GPIO_BASE < IO_SPAN) begin
            case (adr[3:2])
                GPIO_OUT: value = wb_data_t'(shadow_out);
                GPIO_OE:  value = wb_data_t'(shadow_oe);
                GPIO_IN:  value = wb_data_t'(shadow_in);
                default:  value = wb_data_t'(shadow_irq);
            endcase
        end else if (adr - TIMER_BASE < IO_SPAN) begin
            if (adr[3:2] == TIMER_CTRL) begin
                value = wb_data_t'(shadow_ctrl);
            end else if (adr[3:2] == TIMER_CMP) begin
                value = shadow_cmp;
            end
        end
        return value;
    endfunction

    function automatic void model_write(wb_addr_t adr, wb_data_t data, wb_sel_t sel);
        int idx;
        idx = int'(adr[$clog2(RAM_WORDS)+1:2]);
        if (adr - RAM_BASE < wb_addr_t'(RAM_WORDS * 4)) begin
            // Byte merge, unselected lanes keep their old value
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    shadow_ram[idx][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end else if (adr - GPIO_BASE < IO_SPAN) begin
            case (adr[3:2])
                GPIO_OUT: shadow_out = data[7:0];
                GPIO_OE:  shadow_oe  = data[7:0];
                GPIO_IRQ: shadow_irq = shadow_irq & ~data[7:0];
                default:  ;
            endcase
        end else if (adr - TIMER_BASE < IO_SPAN) begin
            if (adr[3:2] == TIMER_CTRL) begin
                shadow_ctrl = data[1:0];
            end else if (adr[3:2] == TIMER_CMP) begin
                shadow_cmp = data;
            end
        end
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic check_data(input string what, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("mismatch at %0t: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_err(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_errs++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_vector(input string what, input irq_vec_t got, input irq_vec_t exp);
        if (got !== exp) begin
            vec_errs++;
            $display("mismatch at %0t: %s vector %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_irq_low(input string what);
        if (irq !== 1'b0) begin
            other_errs++;
            $display("mismatch at %0t: irq_o still high after %s", $time, what);
        end
    endtask

    // ==================================================
    // Bus and pin drivers
    // ==================================================

    // Single classic transfer, result left in rdata, ack_seen and err_seen
    task automatic bus_xfer(input logic we, input wb_addr_t adr, input wb_data_t data,
                            input wb_sel_t sel);
        int waited;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wb_sel   <= sel;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && !wb_err && waited < XFER_WAIT);
        rdata    = wb_dat_r;
        ack_seen = wb_ack;
        err_seen = wb_err;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!ack_seen && !err_seen) begin
            other_errs++;
            $display("no ack and no err from the bus for address %h", adr);
        end else if (waited != RESP_SAMPLE) begin
            other_errs++;
            $display("mismatch at %0t: response to %h on falling edge %0d, expected %0d",
                     $time, adr, waited, RESP_SAMPLE);
        end
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t data, input wb_sel_t sel);
        bus_xfer(1'b1, adr, data, sel);
        check_err($sformatf("err on write to %h", adr), err_seen, 1'b0);
        model_write(adr, data, sel);
    endtask

    task automatic read_compare(input wb_addr_t adr);
        bus_xfer(1'b0, adr, '0, 4'hF);
        check_err($sformatf("err on read of %h", adr), err_seen, 1'b0);
        if (ack_seen) begin
            check_data($sformatf("read of %h", adr), rdata, model_read(adr));
        end
    endtask

    task automatic unmapped_access();
        bus_xfer(1'b0, UNMAPPED, '0, 4'hF);
        check_err("ack on unmapped access", ack_seen, 1'b0);
        check_err("err on unmapped access", err_seen, 1'b1);
    endtask

    task automatic wait_irq(input int limit);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!irq && waited < limit);
        irq_seen = irq;
        if (!irq_seen) begin
            other_errs++;
            $display("irq_o did not rise within %0d cycles", limit);
        end
    endtask

    task automatic ack_irq();
        @(posedge clk);
        irq_ack <= 1'b1;
        @(posedge clk);
        irq_ack <= 1'b0;
        @(negedge clk);
    endtask

    task automatic set_gpio_in(input gpio_t value);
        @(posedge clk);
        gpio_in <= value;
        shadow_irq = shadow_irq | (value & ~shadow_in);
        shadow_in  = value;
    endtask

    // Apply a pin pattern, then check input, status, interrupt and clear
    task automatic gpio_input_round(input gpio_t value);
        set_gpio_in(value);
        repeat (4) @(posedge clk);
        read_compare(reg_addr(GPIO_BASE, GPIO_IN));
        read_compare(reg_addr(GPIO_BASE, GPIO_IRQ));
        wait_irq(10);
        check_vector("GPIO edge", irq_vector, IRQ_GPIO);
        bus_write(reg_addr(GPIO_BASE, GPIO_IRQ), 32'h0000_00FF, 4'hF);
        read_compare(reg_addr(GPIO_BASE, GPIO_IRQ));
        ack_irq();
        check_irq_low("GPIO acknowledge");
    endtask

    // ==================================================
    // Timeout
    // ==================================================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        gpio_in = '0;
        irq_ack = 1'b0;
        shadow_out = '0;
        shadow_oe = '0;
        shadow_in = '0;
        shadow_irq = '0;
        shadow_ctrl = '0;
        shadow_cmp = '0;
        data_errs = 0;
        err_errs = 0;
        vec_errs = 0;
        other_errs = 0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // Let the reset release pass the synchronizer
        repeat (3) @(posedge clk);

        // RAM full words, then byte strobes
        for (int i = 0; i < TEST_WORDS; i++) begin
            bus_write(RAM_BASE + wb_addr_t'(i * 4), $random(seed), 4'hF);
        end
        for (int i = 0; i < TEST_WORDS / 2; i++) begin
            pick = $random(seed);
            bus_write(RAM_BASE + wb_addr_t'({pick[5:0], 2'b00}), $random(seed), pick[11:8]);
        end
        for (int i = 0; i < TEST_WORDS; i++) begin
            read_compare(RAM_BASE + wb_addr_t'(i * 4));
        end

        // Unmapped access
        unmapped_access();
        wait_irq(10);
        check_vector("bus error", irq_vector, IRQ_BUS_ERR);
        ack_irq();
        check_irq_low("bus error acknowledge");

        // GPIO output registers
        bus_write(reg_addr(GPIO_BASE, GPIO_OUT), $random(seed), 4'hF);
        bus_write(reg_addr(GPIO_BASE, GPIO_OE), $random(seed), 4'hF);
        @(negedge clk);
        check_data("gpio_out_o", wb_data_t'(gpio_out), wb_data_t'(shadow_out));
        check_data("gpio_oe_o", wb_data_t'(gpio_oe), wb_data_t'(shadow_oe));
        read_compare(reg_addr(GPIO_BASE, GPIO_OUT));
        read_compare(reg_addr(GPIO_BASE, GPIO_OE));

        // GPIO inputs, second pattern has only some rising bits
        gpio_input_round(8'hA5);
        gpio_input_round(8'h3C);

        // Timer compare interrupt, then priority against a bus error
        bus_write(reg_addr(TIMER_BASE, TIMER_CMP), 32'd20, 4'hF);
        read_compare(reg_addr(TIMER_BASE, TIMER_CMP));
        bus_write(reg_addr(TIMER_BASE, TIMER_CTRL), 32'd3, 4'hF);
        read_compare(reg_addr(TIMER_BASE, TIMER_CTRL));
        wait_irq(40);
        check_vector("timer", irq_vector, IRQ_TIMER);
        unmapped_access();
        @(negedge clk);
        check_vector("bus error over timer", irq_vector, IRQ_BUS_ERR);
        ack_irq();
        check_vector("timer after bus error", irq_vector, IRQ_TIMER);
        bus_write(reg_addr(TIMER_BASE, TIMER_CTRL), 32'd0, 4'hF);
        ack_irq();
        check_irq_low("timer acknowledge");

        $display("errors: data %0d, err %0d, vector %0d, other %0d",
                 data_errs, err_errs, vec_errs, other_errs);
        if (data_errs + err_errs + vec_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_basic_system

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule : tb_clock_gen

// ==== verilog/basic_system.sv ====
`timescale 1ns/1ps

module basic_system (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Host bus
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  soc_pkg::wb_addr_t  wb_adr_i,
    input  soc_pkg::wb_data_t  wb_dat_i,
    input  soc_pkg::wb_sel_t   wb_sel_i,
    output soc_pkg::wb_data_t  wb_dat_o,
    output logic               wb_ack_o,
    output logic               wb_err_o,

    // GPIO pins
    input  soc_pkg::gpio_t     gpio_in_i,
    output soc_pkg::gpio_t     gpio_out_o,
    output soc_pkg::gpio_t     gpio_oe_o,

    // Interrupt line
    output logic               irq_o,
    output soc_pkg::irq_vec_t  irq_vector_o,
    input  logic               irq_ack_i
);

    import soc_pkg::*;

    // Reset release through two flops
    logic rst_sync_q, sys_rst_n;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_sync_q <= 1'b0;
            sys_rst_n  <= 1'b0;
        end else begin
            rst_sync_q <= 1'b1;
            sys_rst_n  <= rst_sync_q;
        end
    end

    // ==================================================
    // Bus fabric
    // ==================================================

    wb_bus_if host();
    wb_bus_if ram_bus();
    wb_bus_if timer_bus();
    wb_bus_if gpio_bus();

    assign host.cyc   = wb_cyc_i;
    assign host.stb   = wb_stb_i;
    assign host.we    = wb_we_i;
    assign host.adr   = wb_adr_i;
    assign host.dat_w = wb_dat_i;
    assign host.sel   = wb_sel_i;
    assign wb_dat_o   = host.dat_r;
    assign wb_ack_o   = host.ack;
    assign wb_err_o   = host.err;

    irq_src_t irq_sources;

    wb_decoder u_decoder (
        .clk_i       ( clk_i                    ),
        .rst_n_i     ( sys_rst_n                ),
        .host        ( host                     ),
        .ram_bus     ( ram_bus                  ),
        .timer_bus   ( timer_bus                ),
        .gpio_bus    ( gpio_bus                 ),
        .bus_error_o ( irq_sources[IRQ_BUS_ERR] )
    );

    // ==================================================
    // Slaves and interrupts
    // ==================================================

    on_chip_ram u_ram (
        .clk_i   ( clk_i     ),
        .rst_n_i ( sys_rst_n ),
        .bus     ( ram_bus   )
    );

    timer u_timer (
        .clk_i   ( clk_i                  ),
        .rst_n_i ( sys_rst_n              ),
        .bus     ( timer_bus              ),
        .event_o ( irq_sources[IRQ_TIMER] )
    );

    gpio u_gpio (
        .clk_i   ( clk_i                 ),
        .rst_n_i ( sys_rst_n             ),
        .bus     ( gpio_bus              ),
        .pins_i  ( gpio_in_i             ),
        .pins_o  ( gpio_out_o            ),
        .oe_o    ( gpio_oe_o             ),
        .event_o ( irq_sources[IRQ_GPIO] )
    );

    interrupt_controller u_irq_ctrl (
        .clk_i    ( clk_i        ),
        .rst_n_i  ( sys_rst_n    ),
        .source_i ( irq_sources  ),
        .ack_i    ( irq_ack_i    ),
        .irq_o    ( irq_o        ),
        .vector_o ( irq_vector_o )
    );

endmodule : basic_system

// ==== verilog/gpio.sv ====
`timescale 1ns/1ps

module gpio (
    input  logic         clk_i,
    input  logic         rst_n_i,
    wb_bus_if.slave      bus,
    input  soc_pkg::gpio_t pins_i,
    output soc_pkg::gpio_t pins_o,
    output soc_pkg::gpio_t oe_o,
    output logic         event_o
);

    import soc_pkg::*;

    gpio_t out_q, oe_q;
    gpio_t sync1_q, sync2_q, prev_q;
    gpio_t irq_q;
    gpio_t rise;
    gpio_t clear;
    logic  event_q;

    logic       req;
    logic       wr_en;
    logic [1:0] reg_idx;

    assign req     = bus.cyc & bus.stb & ~bus.ack;
    assign wr_en   = req & bus.we;
    assign reg_idx = bus.adr[3:2];

    // Edge detect on the synchronized value
    assign rise  = sync2_q & ~prev_q;
    assign clear = (wr_en && reg_idx == GPIO_IRQ) ? bus.dat_w[7:0] : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q   <= '0;
            oe_q    <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
            irq_q   <= '0;
            event_q <= 1'b0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
            sync1_q <= pins_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            if (wr_en && reg_idx == GPIO_OUT) begin
                out_q <= bus.dat_w[7:0];
            end
            if (wr_en && reg_idx == GPIO_OE) begin
                oe_q <= bus.dat_w[7:0];
            end
            // A new edge wins over a clear in the same cycle
            irq_q   <= (irq_q & ~clear) | rise;
            event_q <= |(rise & ~irq_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            case (reg_idx)
                GPIO_OUT: bus.dat_r <= wb_data_t'(out_q);
                GPIO_OE:  bus.dat_r <= wb_data_t'(oe_q);
                GPIO_IN:  bus.dat_r <= wb_data_t'(sync2_q);
                default:  bus.dat_r <= wb_data_t'(irq_q);
            endcase
        end
    end

    assign bus.err = 1'b0;
    assign pins_o  = out_q;
    assign oe_o    = oe_q;
    assign event_o = event_q;

endmodule : gpio

// ==== verilog/interrupt_controller.sv ====
`timescale 1ns/1ps

module interrupt_controller (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  soc_pkg::irq_src_t  source_i,
    input  logic               ack_i,
    output logic               irq_o,
    output soc_pkg::irq_vec_t  vector_o
);

    import soc_pkg::*;

    irq_src_t pending_q;
    irq_src_t clear;

    // Fixed priority, lowest number wins
    always_comb begin
        vector_o = '0;
        for (int i = IRQ_SOURCES - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                vector_o = irq_vec_t'(i);
            end
        end
    end

    assign irq_o = |pending_q;
    assign clear = (ack_i && irq_o) ? irq_src_t'(1) << vector_o : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            // Fresh pulse is kept even when acked in the same cycle
            pending_q <= (pending_q & ~clear) | source_i;
        end
    end

    // Vector names a pending source with no lower one pending
    a_vector_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_o |-> (int'(vector_o) < IRQ_SOURCES) && pending_q[vector_o]
                  && ((pending_q & ((irq_src_t'(1) << vector_o) - 1'b1)) == '0));

endmodule : interrupt_controller

// ==== verilog/on_chip_ram.sv ====
`timescale 1ns/1ps

module on_chip_ram (
    input logic     clk_i,
    input logic     rst_n_i,
    wb_bus_if.slave bus
);

    import soc_pkg::*;

    wb_data_t mem [RAM_WORDS];

    wb_addr_t                       ram_offset;
    logic [$clog2(RAM_WORDS)-1:0]   word_idx;
    logic                           req;
    logic                           wr_en;

    // Word index after base removal
    assign ram_offset = bus.adr - RAM_BASE;
    assign word_idx   = ram_offset[$clog2(RAM_WORDS)+1:2];

    // Skip the cycle right after an ack
    assign req   = bus.cyc & bus.stb & ~bus.ack;
    assign wr_en = req & bus.we;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
                end
            end
        end
        if (req) begin
            bus.dat_r <= mem[word_idx];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
        end
    end

    // RAM never faults
    assign bus.err = 1'b0;

    a_ack_with_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus.ack |-> bus.stb);

endmodule : on_chip_ram

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

    // ==================================================
    // Bus and port types
    // ==================================================

    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    typedef logic [7:0] gpio_t;

    localparam int IRQ_SOURCES = 3;

    typedef logic [IRQ_SOURCES-1:0] irq_src_t;
    typedef logic [1:0]             irq_vec_t;

    // ==================================================
    // Address map
    // ==================================================

    localparam wb_addr_t RAM_BASE   = 32'h0000_0000;
    localparam int       RAM_WORDS  = 1024;
    localparam wb_addr_t TIMER_BASE = 32'h1000_0000;
    localparam wb_addr_t GPIO_BASE  = 32'h1000_0100;
    localparam wb_addr_t IO_SPAN    = 32'd16;

    // Word index inside an I/O window
    localparam logic [1:0] TIMER_CTRL = 2'd0;
    localparam logic [1:0] TIMER_CMP  = 2'd1;
    localparam logic [1:0] TIMER_CNT  = 2'd2;

    localparam logic [1:0] GPIO_OUT = 2'd0;
    localparam logic [1:0] GPIO_OE  = 2'd1;
    localparam logic [1:0] GPIO_IN  = 2'd2;
    localparam logic [1:0] GPIO_IRQ = 2'd3;

    // Interrupt numbers, lowest wins
    localparam irq_vec_t IRQ_BUS_ERR = 2'd0;
    localparam irq_vec_t IRQ_TIMER   = 2'd1;
    localparam irq_vec_t IRQ_GPIO    = 2'd2;

endpackage : soc_pkg

// ==== verilog/timer.sv ====
`timescale 1ns/1ps

module timer (
    input  logic     clk_i,
    input  logic     rst_n_i,
    wb_bus_if.slave  bus,
    output logic     event_o
);

    import soc_pkg::*;

    // ctrl_q[0] enable, ctrl_q[1] interrupt enable
    logic [1:0] ctrl_q;
    wb_data_t   cmp_q;
    wb_data_t   cnt_q;

    logic       req;
    logic       wr_en;
    logic       hit_cmp;
    logic [1:0] reg_idx;

    assign req     = bus.cyc & bus.stb & ~bus.ack;
    assign wr_en   = req & bus.we;
    assign reg_idx = bus.adr[3:2];
    assign hit_cmp = ctrl_q[0] & (cnt_q == cmp_q);

    // ==================================================
    // Registers and counter
    // ==================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q  <= '0;
            cmp_q   <= '0;
            cnt_q   <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
            if (wr_en && reg_idx == TIMER_CTRL) begin
                ctrl_q <= bus.dat_w[1:0];
            end
            if (wr_en && reg_idx == TIMER_CMP) begin
                cmp_q <= bus.dat_w;
            end
            // Count wraps to zero after matching compare
            if (hit_cmp) begin
                cnt_q <= '0;
            end else if (ctrl_q[0]) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            case (reg_idx)
                TIMER_CTRL: bus.dat_r <= wb_data_t'(ctrl_q);
                TIMER_CMP:  bus.dat_r <= cmp_q;
                TIMER_CNT:  bus.dat_r <= cnt_q;
                default:    bus.dat_r <= '0;
            endcase
        end
    end

    assign bus.err = 1'b0;
    assign event_o = hit_cmp & ctrl_q[1];

endmodule : timer

// ==== verilog/wb_bus_if.sv ====
`timescale 1ns/1ps

interface wb_bus_if;

    import soc_pkg::*;

    // Request side
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_sel_t  sel;

    // Response side
    wb_data_t dat_r;
    logic     ack;
    logic     err;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack, err
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack, err
    );

endinterface : wb_bus_if

// ==== verilog/wb_decoder.sv ====
`timescale 1ns/1ps

module wb_decoder (
    input  logic     clk_i,
    input  logic     rst_n_i,
    wb_bus_if.slave  host,
    wb_bus_if.master ram_bus,
    wb_bus_if.master timer_bus,
    wb_bus_if.master gpio_bus,
    output logic     bus_error_o
);

    import soc_pkg::*;

    logic ram_hit, timer_hit, gpio_hit;
    logic err_q;

    // Offset compare also covers a base of zero
    assign ram_hit   = (host.adr - RAM_BASE) < wb_addr_t'(RAM_WORDS * 4);
    assign timer_hit = (host.adr - TIMER_BASE) < IO_SPAN;
    assign gpio_hit  = (host.adr - GPIO_BASE) < IO_SPAN;

    // ==================================================
    // Request fan-out
    // ==================================================

    assign ram_bus.cyc   = host.cyc;
    assign ram_bus.stb   = host.stb & ram_hit;
    assign ram_bus.we    = host.we;
    assign ram_bus.adr   = host.adr;
    assign ram_bus.dat_w = host.dat_w;
    assign ram_bus.sel   = host.sel;

    assign timer_bus.cyc   = host.cyc;
    assign timer_bus.stb   = host.stb & timer_hit;
    assign timer_bus.we    = host.we;
    assign timer_bus.adr   = host.adr;
    assign timer_bus.dat_w = host.dat_w;
    assign timer_bus.sel   = host.sel;

    assign gpio_bus.cyc   = host.cyc;
    assign gpio_bus.stb   = host.stb & gpio_hit;
    assign gpio_bus.we    = host.we;
    assign gpio_bus.adr   = host.adr;
    assign gpio_bus.dat_w = host.dat_w;
    assign gpio_bus.sel   = host.sel;

    // ==================================================
    // Response return
    // ==================================================

    always_comb begin
        host.dat_r = '0;
        if (ram_hit) begin
            host.dat_r = ram_bus.dat_r;
        end else if (timer_hit) begin
            host.dat_r = timer_bus.dat_r;
        end else if (gpio_hit) begin
            host.dat_r = gpio_bus.dat_r;
        end
    end

    assign host.ack = ram_bus.ack | timer_bus.ack | gpio_bus.ack;

    // Unmapped access, one cycle of err like a slave ack
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= host.cyc & host.stb & ~(ram_hit | timer_hit | gpio_hit) & ~err_q;
        end
    end

    assign host.err    = err_q;
    assign bus_error_o = err_q;

    a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({ram_bus.stb, timer_bus.stb, gpio_bus.stb}));

endmodule : wb_decoder
